// File: sources.f
+incdir+src
src/lc3b_types.sv
src/control_rom.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/lc3b_alu_pipe.sv
sim/lc3b_alu_pipe_properties.sv
sim/lc3b_alu_pipe_tb.sv

// File: sim/lc3b_alu_pipe_tb.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_alu_pipe_tb;

    import lc3b_types::*;

    typedef struct packed {
        logic [31:0]            due;   // cycle count at which the slot is checked
        logic [3:0]             phase;
        logic                   wr;
        logic [`LC3B_RADDR-1:0] dest;
        logic [`LC3B_WORD-1:0]  data;
    } slot_t;

    logic                   clk;
    logic                   arst_n;
    logic                   instr_valid;
    logic [`LC3B_WORD-1:0]  instr;
    logic                   flush;
    logic                   wb_valid;
    logic [`LC3B_RADDR-1:0] wb_dest;
    logic [`LC3B_WORD-1:0]  wb_data;
    logic [2:0]             cc;

    logic [`LC3B_REGS-1:0][`LC3B_WORD-1:0] model_rf;
    slot_t       slot_q [$];
    logic [31:0] cycle_cnt;
    logic [3:0]  phase;
    logic [2:0]  exp_cc;
    integer      seed;

    lc3b_alu_pipe uut
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .cc          (cc)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic string phase_name(input logic [3:0] p);
        case (p)
            4'd2:    return "immediate";
            4'd3:    return "register bypass";
            4'd4:    return "shift";
            4'd5:    return "no-write";
            4'd6:    return "random";
            default: return "reset";
        endcase
    endfunction

    function automatic logic [15:0] make_instr(input lc3b_opcode op, input logic [2:0] dst,
                                               input logic [2:0] src, input logic [5:0] low);
        return {op, dst, src, low};
    endfunction

    // returns {write, dest, value} as the ISA defines them
    function automatic logic [19:0] expect_result(
        input logic [`LC3B_REGS-1:0][`LC3B_WORD-1:0] rf,
        input logic [`LC3B_WORD-1:0]                 ins,
        input logic                                  vld,
        input logic                                  fl
    );
        logic [`LC3B_WORD-1:0] a;
        logic [`LC3B_WORD-1:0] b;
        logic [`LC3B_WORD-1:0] res;
        logic                  wr;
        a   = rf[ins[8:6]];
        b   = ins[5] ? {{11{ins[4]}}, ins[4:0]} : rf[ins[2:0]];
        wr  = vld && !fl;
        res = '0;
        case (ins[15:12])
            op_add:
                if (ins[5] || ins[4:3] == 2'b00)
                    res = a + b;
                else if (ins[4:3] == 2'b01)
                    res = a * b; // low 16 bits only
                else
                    res = a - b;
            op_and:
                if (ins[5] || ins[4:3] == 2'b00)
                    res = a & b;
                else if (ins[4:3] == 2'b01)
                    res = a | b;
                else if (ins[4:3] == 2'b10)
                    res = a ^ b;
                else
                    wr = 1'b0; // illegal extension
            op_not:
                res = ~a;
            op_shf:
            begin
                if (!ins[4])
                    res = a << ins[3:0];
                else
                    res = a >> ins[3:0];
                if (ins[4] && ins[5] && a[15])
                    res = res | ~(16'hffff >> ins[3:0]); // refill the sign bits
            end
            default:
                wr = 1'b0;
        endcase
        return {wr, ins[11:9], res};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic issue(input logic [15:0] ins, input logic fl, input logic vld);
        logic [19:0] r;
        slot_t       s;
        @(negedge clk);
        instr       = ins;
        flush       = fl;
        instr_valid = vld;
        r = expect_result(model_rf, ins, vld, fl);
        if (r[19])
            model_rf[r[18:16]] = r[15:0];
        s.due   = cycle_cnt + 2; // sampled next edge, in wb regs one edge later
        s.phase = phase;
        s.wr    = r[19];
        s.dest  = r[18:16];
        s.data  = r[15:0];
        slot_q.push_back(s);
    endtask

    // compare process, runs on the falling edge where outputs are settled
    always @(negedge clk)
    begin
        slot_t s;
        if (uut.u_props.fail_cnt != 0)
        begin
            $display("a bound assertion on the DUT failed");
            $display("Testbench failed");
            $fatal(1);
        end
        if (arst_n)
        begin
            check_value("cc", exp_cc, cc);
            if (slot_q.size() != 0 && slot_q[0].due == cycle_cnt)
            begin
                s = slot_q.pop_front();
                check_value({phase_name(s.phase), " wb_valid"}, s.wr, wb_valid);
                if (s.wr)
                begin
                    check_value({phase_name(s.phase), " wb_dest"}, s.dest, wb_dest);
                    check_value({phase_name(s.phase), " wb_data"}, s.data, wb_data);
                    exp_cc = {$signed(s.data) < 0, s.data == 0, $signed(s.data) > 0};
                end
            end
            else
                check_value("idle wb_valid", 1'b0, wb_valid);
        end
    end

    initial
    begin
        logic [4:0]  imm;
        logic [15:0] ins;
        logic [31:0] pick;
        int          wait_cnt;
        clk = 1'b0;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        flush = 1'b0;
        cycle_cnt = '0;
        model_rf = '0;
        exp_cc = 3'b010;
        phase = 4'd1;
        seed = 32'h5f0f;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_value("reset wb_valid", 1'b0, wb_valid);
        check_value("reset cc", 3'b010, cc);

        phase = 4'd2;
        for (int r = 0; r < 8; r++)
        begin
            imm = 5'(r * 4 - 13);
            issue(make_instr(op_and, r[2:0], r[2:0], 6'b100000), 1'b0, 1'b1); // clear
            issue(make_instr(op_add, r[2:0], r[2:0], {1'b1, imm}), 1'b0, 1'b1);
        end
        issue(make_instr(op_and, 3'd1, 3'd3, 6'b111110), 1'b0, 1'b1); // -1 & -2

        phase = 4'd3;
        issue(make_instr(op_add, 3'd0, 3'd4, 6'b000101), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd1, 3'd0, 6'b001000), 1'b0, 1'b1); // mul, both bypassed
        issue(make_instr(op_add, 3'd2, 3'd1, 6'b010111), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd3, 3'd2, 6'b011000), 1'b0, 1'b1);
        issue(make_instr(op_and, 3'd4, 3'd3, 6'b001001), 1'b0, 1'b1); // or
        issue(make_instr(op_and, 3'd5, 3'd4, 6'b010010), 1'b0, 1'b1); // xor
        issue(make_instr(op_and, 3'd6, 3'd5, 6'b000011), 1'b0, 1'b1);
        issue(make_instr(op_not, 3'd7, 3'd6, 6'b111111), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd0, 3'd7, 6'b001111), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd1, 3'd5, 6'b000111), 1'b0, 1'b1); // r5 via regfile

        phase = 4'd4;
        issue(make_instr(op_and, 3'd1, 3'd1, 6'b100000), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd1, 3'd1, 6'b111001), 1'b0, 1'b1); // -7
        issue(make_instr(op_and, 3'd3, 3'd3, 6'b100000), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd3, 3'd3, 6'b101101), 1'b0, 1'b1); // 13
        issue(make_instr(op_shf, 3'd2, 3'd1, 6'b000011), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd4, 3'd1, 6'b010100), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd5, 3'd1, 6'b110100), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd6, 3'd3, 6'b110010), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd7, 3'd3, 6'b001111), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd0, 3'd3, 6'b010001), 1'b0, 1'b1);
        issue(make_instr(op_shf, 3'd0, 3'd0, 6'b100001), 1'b0, 1'b1); // a set, d clear

        phase = 4'd5;
        issue(make_instr(op_add, 3'd0, 3'd0, 6'b101111), 1'b1, 1'b1);
        issue(make_instr(op_and, 3'd0, 3'd1, 6'b011010), 1'b0, 1'b1);
        issue(make_instr(op_ldr, 3'd0, 3'd1, 6'b000101), 1'b0, 1'b1);
        issue(make_instr(op_add, 3'd0, 3'd0, 6'b100111), 1'b0, 1'b0);
        issue(make_instr(op_add, 3'd1, 3'd0, 6'b100000), 1'b0, 1'b1); // r0 untouched

        phase = 4'd6;
        for (int n = 0; n < 300; n++)
        begin
            ins  = 16'($random(seed));
            pick = $random(seed);
            if (pick[1:0] != 2'b00)
                ins[15:12] = {pick[3:2], 2'b01}; // add, and, not, shf all end in 01
            issue(ins, pick[6:4] == 3'b000, pick[9:7] != 3'b000);
        end
        issue(16'h0000, 1'b0, 1'b0);

        for (wait_cnt = 0; slot_q.size() != 0 && wait_cnt < 20; wait_cnt++)
            @(posedge clk);
        repeat (2) @(posedge clk); // let the last cc update be compared
        if (slot_q.size() != 0)
        begin
            $display("writeback slots still pending after the drain timeout");
            $display("Testbench failed");
            $fatal(1);
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule : lc3b_alu_pipe_tb

// File: sim/lc3b_alu_pipe_properties.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_alu_pipe_properties
(
    input logic                  clk,
    input logic                  arst_n,
    input logic                  instr_valid,
    input logic [`LC3B_WORD-1:0] instr,
    input logic                  flush,
    input logic                  wb_valid,
    input logic [2:0]            cc
);

    import lc3b_types::*;

    logic writes;
    int   fail_cnt = 0; // assertion failures seen so far

    // kept op that is not the illegal and extension
    assign writes = instr_valid && !flush &&
                    (instr[15:12] == op_add || instr[15:12] == op_not ||
                     instr[15:12] == op_shf ||
                     (instr[15:12] == op_and && (instr[5] || instr[4:3] != 2'b11)));

    wb_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(wb_valid))
        else
        begin
            fail_cnt++;
            $error("wb_valid is unknown");
        end

    cc_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(cc))
        else
        begin
            fail_cnt++;
            $error("cc is not one-hot");
        end

    wb_follows_write: assert property (@(posedge clk) disable iff (!arst_n)
        writes |-> ##2 wb_valid)
        else
        begin
            fail_cnt++;
            $error("accepted instruction gave no writeback two cycles later");
        end

    wb_quiet_otherwise: assert property (@(posedge clk) disable iff (!arst_n)
        !writes |-> ##2 !wb_valid)
        else
        begin
            fail_cnt++;
            $error("writeback without a writing instruction two cycles earlier");
        end

endmodule : lc3b_alu_pipe_properties

bind lc3b_alu_pipe lc3b_alu_pipe_properties u_props
(
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .flush       (flush),
    .wb_valid    (wb_valid),
    .cc          (cc)
);

// File: src/lc3b_alu_pipe.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_alu_pipe
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  logic [`LC3B_WORD-1:0]   instr,
    input  logic                    flush,
    output logic                    wb_valid,
    output logic [`LC3B_RADDR-1:0]  wb_dest,
    output logic [`LC3B_WORD-1:0]   wb_data,
    output logic [2:0]              cc
);

    import lc3b_types::*;

    logic                   d_valid;
    lc3b_aluop              d_aluop;
    logic                   d_use_imm;
    logic [`LC3B_WORD-1:0]  d_imm;
    logic                   d_shift_right;
    logic                   d_shift_arith;
    logic [3:0]             d_shamt;
    logic [`LC3B_RADDR-1:0] d_dest;
    logic [`LC3B_RADDR-1:0] d_sr1;
    logic [`LC3B_RADDR-1:0] d_sr2;
    logic [`LC3B_RADDR-1:0] rd_addr1;
    logic [`LC3B_RADDR-1:0] rd_addr2;
    logic [`LC3B_WORD-1:0]  rd_data1;
    logic [`LC3B_WORD-1:0]  rd_data2;

    decode_stage u_decode
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .flush         (flush),
        .d_valid       (d_valid),
        .d_aluop       (d_aluop),
        .d_use_imm     (d_use_imm),
        .d_imm         (d_imm),
        .d_shift_right (d_shift_right),
        .d_shift_arith (d_shift_arith),
        .d_shamt       (d_shamt),
        .d_dest        (d_dest),
        .d_sr1         (d_sr1),
        .d_sr2         (d_sr2)
    );

    execute_stage u_execute
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .d_valid       (d_valid),
        .d_aluop       (d_aluop),
        .d_use_imm     (d_use_imm),
        .d_imm         (d_imm),
        .d_shift_right (d_shift_right),
        .d_shift_arith (d_shift_arith),
        .d_shamt       (d_shamt),
        .d_dest        (d_dest),
        .d_sr1         (d_sr1),
        .d_sr2         (d_sr2),
        .rd_data1      (rd_data1),
        .rd_data2      (rd_data2),
        .rd_addr1      (rd_addr1),
        .rd_addr2      (rd_addr2),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

    result_stage u_result
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .cc       (cc)
    );

endmodule : lc3b_alu_pipe

// File: src/result_stage.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module result_stage
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`LC3B_RADDR-1:0]  rd_addr1,
    input  logic [`LC3B_RADDR-1:0]  rd_addr2,
    input  logic                    wb_valid,
    input  logic [`LC3B_RADDR-1:0]  wb_dest,
    input  logic [`LC3B_WORD-1:0]   wb_data,
    output logic [`LC3B_WORD-1:0]   rd_data1,
    output logic [`LC3B_WORD-1:0]   rd_data2,
    output logic [2:0]              cc
);

    logic [`LC3B_WORD-1:0] regs [`LC3B_REGS];
    logic [2:0]            nzp;

    assign rd_data1 = regs[rd_addr1]; // async read ports
    assign rd_data2 = regs[rd_addr2];

    assign nzp = wb_data[`LC3B_WORD-1] ? 3'b100 :
                 (wb_data == '0)       ? 3'b010 :
                                         3'b001;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `LC3B_REGS; i++)
            begin
                regs[i] <= '0;
            end
            cc <= 3'b010; // z out of reset
        end
        else if (wb_valid)
        begin
            regs[wb_dest] <= wb_data;
            cc            <= nzp;
        end
    end

endmodule : result_stage

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module execute_stage
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    d_valid,
    input  lc3b_types::lc3b_aluop   d_aluop,
    input  logic                    d_use_imm,
    input  logic [`LC3B_WORD-1:0]   d_imm,
    input  logic                    d_shift_right,
    input  logic                    d_shift_arith,
    input  logic [3:0]              d_shamt,
    input  logic [`LC3B_RADDR-1:0]  d_dest,
    input  logic [`LC3B_RADDR-1:0]  d_sr1,
    input  logic [`LC3B_RADDR-1:0]  d_sr2,
    input  logic [`LC3B_WORD-1:0]   rd_data1,
    input  logic [`LC3B_WORD-1:0]   rd_data2,
    output logic [`LC3B_RADDR-1:0]  rd_addr1,
    output logic [`LC3B_RADDR-1:0]  rd_addr2,
    output logic                    wb_valid,
    output logic [`LC3B_RADDR-1:0]  wb_dest,
    output logic [`LC3B_WORD-1:0]   wb_data
);

    import lc3b_types::*;

    logic [`LC3B_WORD-1:0] op_a;
    logic [`LC3B_WORD-1:0] op_b;
    logic [`LC3B_WORD-1:0] alu_b;
    logic [`LC3B_WORD-1:0] product;
    logic [`LC3B_WORD-1:0] shf_out;
    logic [`LC3B_WORD-1:0] alu_out;

    assign rd_addr1 = d_sr1;
    assign rd_addr2 = d_sr2;

    // the instruction one ahead is still in wb regs, not yet in the regfile
    assign op_a = (wb_valid && wb_dest == d_sr1) ? wb_data : rd_data1;
    assign op_b = (wb_valid && wb_dest == d_sr2) ? wb_data : rd_data2;

    assign alu_b   = d_use_imm ? d_imm : op_b;
    assign product = op_a * alu_b; // truncates to the low 16 bits

    always_comb
    begin
        if (!d_shift_right)
            shf_out = op_a << d_shamt;
        else if (d_shift_arith)
            shf_out = $signed(op_a) >>> d_shamt; // sign fill
        else
            shf_out = op_a >> d_shamt;
    end

    always_comb
    begin
        case (d_aluop)
            alu_add: alu_out = op_a + alu_b;
            alu_sub: alu_out = op_a - alu_b;
            alu_mul: alu_out = product;
            alu_and: alu_out = op_a & alu_b;
            alu_or:  alu_out = op_a | alu_b;
            alu_xor: alu_out = op_a ^ alu_b;
            alu_not: alu_out = ~op_a;
            default: alu_out = shf_out;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= d_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_dest <= d_dest;
        wb_data <= alu_out;
    end

endmodule : execute_stage

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module decode_stage
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  logic [`LC3B_WORD-1:0]   instr,
    input  logic                    flush,
    output logic                    d_valid,
    output lc3b_types::lc3b_aluop   d_aluop,
    output logic                    d_use_imm,
    output logic [`LC3B_WORD-1:0]   d_imm,
    output logic                    d_shift_right,
    output logic                    d_shift_arith,
    output logic [3:0]              d_shamt,
    output logic [`LC3B_RADDR-1:0]  d_dest,
    output logic [`LC3B_RADDR-1:0]  d_sr1,
    output logic [`LC3B_RADDR-1:0]  d_sr2
);

    import lc3b_types::*;

    lc3b_opcode            opcode;
    lc3b_lc3x              lc3x;
    logic [`LC3B_WORD-1:0] imm_sext;
    logic                  rom_load_regfile;
    logic                  rom_load_cc;
    lc3b_aluop             rom_aluop;
    logic                  rom_alumux_imm;
    logic                  rom_shift_right;
    logic                  rom_shift_arith;

    assign opcode   = lc3b_opcode'(instr[15:12]);
    assign lc3x     = lc3b_lc3x'(instr[4:3]);
    assign imm_sext = {{(`LC3B_WORD-5){instr[4]}}, instr[4:0]}; // sext(imm5)

    control_rom u_rom
    (
        .opcode       (opcode),
        .lc3x_check   (lc3x),
        .imm_enable   (instr[5]),
        .d_enable     (instr[4]),
        .flush_enable (flush),
        .load_regfile (rom_load_regfile),
        .load_cc      (rom_load_cc),
        .aluop        (rom_aluop),
        .alumux_imm   (rom_alumux_imm),
        .shift_right  (rom_shift_right),
        .shift_arith  (rom_shift_arith)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            d_valid <= 1'b0;
        end
        else
        begin
            // every kept op writes both a register and cc
            d_valid <= instr_valid & rom_load_regfile & rom_load_cc;
        end
    end

    always_ff @(posedge clk)
    begin
        d_aluop       <= rom_aluop;
        d_use_imm     <= rom_alumux_imm;
        d_imm         <= imm_sext;
        d_shift_right <= rom_shift_right;
        d_shift_arith <= rom_shift_arith;
        d_shamt       <= instr[3:0];
        d_dest        <= instr[11:9];
        d_sr1         <= instr[8:6];
        d_sr2         <= instr[2:0];
    end

endmodule : decode_stage

// File: src/control_rom.sv
`timescale 1ns/1ps

module control_rom
(
    input  lc3b_types::lc3b_opcode opcode,
    input  lc3b_types::lc3b_lc3x   lc3x_check,
    input  logic                   imm_enable,
    input  logic                   d_enable,
    input  logic                   flush_enable,
    output logic                   load_regfile,
    output logic                   load_cc,
    output lc3b_types::lc3b_aluop  aluop,
    output logic                   alumux_imm,
    output logic                   shift_right,
    output logic                   shift_arith
);

    import lc3b_types::*;

    always_comb
    begin
        load_regfile = 1'b0; // all-zero word is the nop
        load_cc      = 1'b0;
        aluop        = alu_add;
        alumux_imm   = 1'b0;
        shift_right  = 1'b0;
        shift_arith  = 1'b0;

        if (!flush_enable)
        begin
            case (opcode)
                op_add:
                begin
                    load_regfile = 1'b1;
                    load_cc      = 1'b1;
                    if (imm_enable)
                    begin
                        alumux_imm = 1'b1; // sr1 + sext(imm5)
                    end
                    else
                    begin
                        case (lc3x_check)
                            x_base:  aluop = alu_add;
                            x_ext1:  aluop = alu_mul;  // low half of product
                            default: aluop = alu_sub;  // 10 and 11 both subtract
                        endcase
                    end
                end

                op_and:
                begin
                    aluop        = alu_and;
                    load_regfile = 1'b1;
                    load_cc      = 1'b1;
                    if (imm_enable)
                    begin
                        alumux_imm = 1'b1;
                    end
                    else
                    begin
                        case (lc3x_check)
                            x_base: aluop = alu_and;
                            x_ext1: aluop = alu_or;
                            x_ext2: aluop = alu_xor;
                            default:
                            begin
                                aluop        = alu_add; // illegal, back to zero word
                                load_regfile = 1'b0;
                                load_cc      = 1'b0;
                            end
                        endcase
                    end
                end

                op_not:
                begin
                    aluop        = alu_not;
                    load_regfile = 1'b1;
                    load_cc      = 1'b1;
                end

                op_shf:
                begin
                    aluop        = alu_shf;
                    shift_right  = d_enable;              // d bit, IR[4]
                    shift_arith  = d_enable & imm_enable; // a bit only matters going right
                    load_regfile = 1'b1;
                    load_cc      = 1'b1;
                end

                default:
                begin
                    // memory, control flow and rti leave the word at zero
                    load_regfile = 1'b0;
                end
            endcase
        end
    end

endmodule : control_rom

// File: src/lc3b_types.sv
package lc3b_types;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // IR[4:3] of register-form ADD and AND
    typedef enum logic [1:0] {
        x_base = 2'b00,
        x_ext1 = 2'b01,
        x_ext2 = 2'b10,
        x_ext3 = 2'b11
    } lc3b_lc3x;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_mul,
        alu_and,
        alu_or,
        alu_xor,
        alu_not,
        alu_shf // direction and fill from separate bits
    } lc3b_aluop;

endpackage : lc3b_types

// File: src/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// datapath and instruction width
`define LC3B_WORD 16

// register file size and its address width
`define LC3B_REGS 8
`define LC3B_RADDR 3

`endif
